//--- project.f
+incdir+.
denoise_pkg.sv
frame_config.sv
block_buffer.sv
block_stats.sv
noise_estimator.sv
wiener_gain.sv
denoise_top.sv
tb_denoise_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_denoise_top -f project.f

result=$(./obj_dir/Vtb_denoise_top 2>&1 || true)
printf '%s\n' "$result"

# Fails the script unless the pass line is present
printf '%s\n' "$result" | grep -qx "NO ERRORS"

//--- tb_model.svh
// Reference model of block statistics, Wiener gain, filtered pixels and the noise estimate
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Gray sample is the truncated average of the three channels
function automatic int gray_level(input int r, input int g, input int b);
	return (r + g + b) / 3;
endfunction

// Floor of the block average
function automatic int block_mean(input int sum);
	return sum / denoise_pkg::block_pixels;
endfunction

// Average square minus the squared floored mean
function automatic int block_variance(input int sum, input int sum_sq);
	int m;
	m = block_mean(sum);
	return sum_sq / denoise_pkg::block_pixels - m * m;
endfunction

// Gain in steps of 1/256, zero once noise reaches the block variance
function automatic int expected_gain(input int variance, input int noise);
	if (variance == 0 || variance <= noise)
		return 0;
	return ((variance - noise) * (1 << denoise_pkg::gain_frac)) / variance;
endfunction

// Mean plus the scaled deviation, rounded toward minus infinity and clamped
function automatic int filtered_channel(input int x, input int mean, input int gain);
	int scaled;
	int res;
	scaled = (gain * (x - mean)) >>> denoise_pkg::gain_frac;
	res = mean + scaled;
	if (res < 0)
		return 0;
	if (res > 255)
		return 255;
	return res;
endfunction

// Running minimum of the gray block variances in a frame
function automatic int smaller_var(input int cur, input int v);
	return (v < cur) ? v : cur;
endfunction

`endif

//--- tb_denoise_top.sv
`timescale 1ns/1ps
// Table driven testbench for the block denoiser with a reference model and random back-pressure
module tb_denoise_top;

	localparam int frame_w = 16;
	localparam int frame_h = 16;
	localparam int frame_pix_n = frame_w * frame_h;
	localparam int frame_blocks = frame_pix_n / denoise_pkg::block_pixels;
	localparam int pixel_timeout = 4000;
	localparam int frame_timeout = 40000;

	localparam logic [1:0] kind_random = 2'd0;
	localparam logic [1:0] kind_flat = 2'd1;
	localparam logic [1:0] kind_ramp = 2'd2;

	typedef struct packed {
		logic [1:0] kind;
		logic [7:0] stall_pct;
		logic write_noise;
		logic [15:0] noise_val;
	} frame_entry_t;

	localparam int num_frames = 6;
	localparam frame_entry_t frame_table [num_frames] = '{
		'{kind_random, 8'd0, 1'b1, 16'h0c00},
		'{kind_ramp, 8'd30, 1'b0, 16'h0000},
		'{kind_flat, 8'd50, 1'b0, 16'h0000},
		// Flat frame leaves a zero estimate, so this one passes through unchanged
		'{kind_random, 8'd25, 1'b0, 16'h0000},
		'{kind_ramp, 8'd60, 1'b1, 16'h0200},
		'{kind_random, 8'd40, 1'b0, 16'h0000}
	};

	logic clk;
	logic rst;
	logic cfg_we;
	logic [denoise_pkg::cfg_addr_w-1:0] cfg_addr;
	logic [denoise_pkg::cfg_data_w-1:0] cfg_wdata;
	logic [denoise_pkg::cfg_addr_w-1:0] cfg_raddr;
	logic [denoise_pkg::cfg_data_w-1:0] cfg_rdata;
	logic s_valid;
	logic s_ready;
	denoise_pkg::pixel_t s_data;
	logic s_user;
	logic m_valid;
	logic m_ready;
	denoise_pkg::pixel_t m_data;
	logic m_last;
	logic m_user;

	int stall_pct;
	int model_noise;
	denoise_pkg::pixel_t frame_pix [frame_pix_n];
	// Entries are {user, last, data}
	logic [25:0] exp_q [$];
	logic [25:0] out_q [$];

	`include "tb_model.svh"

	denoise_top denoise_top_i (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_raddr(cfg_raddr),
		.cfg_rdata(cfg_rdata),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.s_data(s_data),
		.s_user(s_user),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.m_data(m_data),
		.m_last(m_last),
		.m_user(m_user)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Output back-pressure
	initial begin
		m_ready = 1'b0;
		forever begin
			@(posedge clk);
			m_ready <= (int'($urandom % 100) >= stall_pct);
		end
	end

	always @(posedge clk) begin
		if (!rst && m_valid && m_ready)
			out_q.push_back({m_user, m_last, m_data});
	end

	task automatic fail_run();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
			fail_run();
		end
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	// Read data is registered one cycle after the address
	task automatic read_check(input logic [1:0] addr, input logic [15:0] expected,
			input string name);
		@(posedge clk);
		cfg_raddr <= addr;
		@(posedge clk);
		@(posedge clk);
		check_value(name, 32'(cfg_rdata), 32'(expected));
	endtask

	task automatic fill_frame(input logic [1:0] kind);
		denoise_pkg::pixel_t color;
		int blk;
		int p;
		int v;
		for (int i = 0; i < frame_pix_n; i++) begin
			blk = i / denoise_pkg::block_pixels;
			p = i % denoise_pkg::block_pixels;
			case (kind)
				kind_flat: begin
					if (p == 0)
						color = 24'($urandom);
					frame_pix[i] = color;
				end
				kind_ramp: begin
					// Diagonal ramp per block with two bits of noise
					v = 30 + blk * 25 + (p % denoise_pkg::block_dim) * 3;
					v = v + (p / denoise_pkg::block_dim) * 2 + int'($urandom % 4);
					frame_pix[i].r = 8'(v);
					frame_pix[i].g = 8'(v + 40);
					frame_pix[i].b = 8'(v + 80);
				end
				default: frame_pix[i] = 24'($urandom);
			endcase
		end
	endtask

	task automatic build_expected(input int noise, output int frame_min);
		int sum [4];
		int sq [4];
		int s [4];
		int mean [3];
		int gain [3];
		int base;
		logic first;
		logic last;
		denoise_pkg::pixel_t pix;
		denoise_pkg::pixel_t res;
		frame_min = 'hffff;
		exp_q.delete();
		for (int blk = 0; blk < frame_blocks; blk++) begin
			base = blk * denoise_pkg::block_pixels;
			for (int c = 0; c < 4; c++) begin
				sum[c] = 0;
				sq[c] = 0;
			end
			for (int p = 0; p < denoise_pkg::block_pixels; p++) begin
				pix = frame_pix[base + p];
				s[0] = pix.r;
				s[1] = pix.g;
				s[2] = pix.b;
				s[3] = gray_level(s[0], s[1], s[2]);
				for (int c = 0; c < 4; c++) begin
					sum[c] += s[c];
					sq[c] += s[c] * s[c];
				end
			end
			for (int c = 0; c < 3; c++) begin
				mean[c] = block_mean(sum[c]);
				gain[c] = expected_gain(block_variance(sum[c], sq[c]), noise);
			end
			frame_min = smaller_var(frame_min, block_variance(sum[3], sq[3]));
			for (int p = 0; p < denoise_pkg::block_pixels; p++) begin
				pix = frame_pix[base + p];
				res.r = 8'(filtered_channel(pix.r, mean[0], gain[0]));
				res.g = 8'(filtered_channel(pix.g, mean[1], gain[1]));
				res.b = 8'(filtered_channel(pix.b, mean[2], gain[2]));
				first = (blk == 0) && (p == 0);
				last = (p == denoise_pkg::block_pixels - 1);
				exp_q.push_back({first, last, res});
			end
		end
	endtask

	task automatic send_frame();
		int waited;
		for (int i = 0; i < frame_pix_n; i++) begin
			s_valid <= 1'b1;
			s_data <= frame_pix[i];
			s_user <= (i == 0);
			waited = 0;
			do begin
				@(posedge clk);
				waited++;
				if (waited > pixel_timeout) begin
					$display("Timeout: input pixel %0d was never accepted", i);
					fail_run();
				end
			end while (!s_ready);
		end
		s_valid <= 1'b0;
		s_user <= 1'b0;
	endtask

	task automatic wait_outputs(input int n);
		int waited;
		waited = 0;
		while (out_q.size() < n) begin
			@(posedge clk);
			waited++;
			if (waited > frame_timeout) begin
				$display("Timeout: only %0d of %0d output pixels arrived", out_q.size(), n);
				fail_run();
			end
		end
	endtask

	task automatic compare_frame(input logic [1:0] kind);
		logic [25:0] got;
		logic [25:0] expected;
		for (int i = 0; i < frame_pix_n; i++) begin
			got = out_q[i];
			expected = exp_q[i];
			check_value("m_data", 32'(got[23:0]), 32'(expected[23:0]));
			check_value("m_last", 32'(got[24]), 32'(expected[24]));
			check_value("m_user", 32'(got[25]), 32'(expected[25]));
			// Zero variance block returns its own colour
			if (kind == kind_flat)
				check_value("m_data", 32'(got[23:0]), 32'(frame_pix[i]));
		end
	endtask

	initial begin
		int seed_val;
		int frame_min;
		frame_entry_t entry;
		seed_val = $urandom(87);
		stall_pct = 0;
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		cfg_raddr = '0;
		s_valid = 1'b0;
		s_data = '0;
		s_user = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_value("s_ready", 32'(s_ready), 32'd1);
		check_value("m_valid", 32'(m_valid), 32'd0);

		// Reset values, then the test frame size
		read_check(denoise_pkg::reg_width, 16'd16, "cfg_rdata width");
		read_check(denoise_pkg::reg_height, 16'd8, "cfg_rdata height");
		read_check(denoise_pkg::reg_noise_est, 16'h0040, "cfg_rdata noise_est");
		write_reg(denoise_pkg::reg_width, 16'(frame_w));
		write_reg(denoise_pkg::reg_height, 16'(frame_h));
		read_check(denoise_pkg::reg_width, 16'(frame_w), "cfg_rdata width");
		read_check(denoise_pkg::reg_height, 16'(frame_h), "cfg_rdata height");
		model_noise = 'h40;

		for (int f = 0; f < num_frames; f++) begin
			entry = frame_table[f];
			stall_pct = int'(entry.stall_pct);
			if (entry.write_noise) begin
				write_reg(denoise_pkg::reg_noise_init, entry.noise_val);
				model_noise = int'(entry.noise_val);
				read_check(denoise_pkg::reg_noise_init, entry.noise_val, "cfg_rdata noise_init");
				read_check(denoise_pkg::reg_noise_est, entry.noise_val, "cfg_rdata noise_est");
			end
			fill_frame(entry.kind);
			build_expected(model_noise, frame_min);
			out_q.delete();
			send_frame();
			wait_outputs(frame_pix_n);
			compare_frame(entry.kind);
			// Next frame is filtered with this frame's smallest gray variance
			model_noise = frame_min;
			read_check(denoise_pkg::reg_noise_est, 16'(model_noise), "cfg_rdata noise_est");
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- denoise_top.sv
`timescale 1ns/1ps
// Block denoiser top level joining configuration, buffer, statistics, noise and gain units
module denoise_top #(
	parameter int block_pixels_p = denoise_pkg::block_pixels
) (
	input  logic                               clk,
	input  logic                               rst,

	// Register port
	input  logic                               cfg_we,
	input  logic [denoise_pkg::cfg_addr_w-1:0] cfg_addr,
	input  logic [denoise_pkg::cfg_data_w-1:0] cfg_wdata,
	input  logic [denoise_pkg::cfg_addr_w-1:0] cfg_raddr,
	output logic [denoise_pkg::cfg_data_w-1:0] cfg_rdata,

	// Pixel stream in, block order
	input  logic                               s_valid,
	output logic                               s_ready,
	input  denoise_pkg::pixel_t                s_data,
	input  logic                               s_user,

	// Filtered pixel stream out
	output logic                               m_valid,
	input  logic                               m_ready,
	output denoise_pkg::pixel_t                m_data,
	output logic                               m_last,
	output logic                               m_user
);

	denoise_pkg::frame_cfg_t cfg;
	logic noise_init_load;
	denoise_pkg::pixel_t pix_in;
	logic pix_in_valid;
	denoise_pkg::block_stats_t stats;
	logic stats_done;
	logic [denoise_pkg::cfg_data_w-1:0] noise_var;
	denoise_pkg::gains_t gains;
	logic gain_done;

	frame_config frame_config_i (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_raddr(cfg_raddr),
		.cfg_rdata(cfg_rdata),
		.noise_var(noise_var),
		.cfg(cfg),
		.noise_init_load(noise_init_load)
	);

	block_buffer #(.block_pixels_p(block_pixels_p)) block_buffer_i (
		.clk(clk),
		.rst(rst),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.s_data(s_data),
		.s_user(s_user),
		.pix_in(pix_in),
		.pix_in_valid(pix_in_valid),
		.stats(stats),
		.gains(gains),
		.gain_done(gain_done),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.m_data(m_data),
		.m_last(m_last),
		.m_user(m_user)
	);

	block_stats #(.block_pixels_p(block_pixels_p)) block_stats_i (
		.clk(clk),
		.rst(rst),
		.pix_in(pix_in),
		.pix_in_valid(pix_in_valid),
		.stats(stats),
		.stats_done(stats_done)
	);

	noise_estimator #(.block_pixels_p(block_pixels_p)) noise_estimator_i (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.noise_init_load(noise_init_load),
		.stats(stats),
		.stats_done(stats_done),
		.noise_var(noise_var)
	);

	wiener_gain wiener_gain_i (
		.clk(clk),
		.rst(rst),
		.stats(stats),
		.stats_done(stats_done),
		.noise_var(noise_var),
		.gains(gains),
		.gain_done(gain_done)
	);

endmodule

//--- wiener_gain.sv
`timescale 1ns/1ps
// Wiener gains for r, g and b by one serial restoring division per channel
module wiener_gain (
	input  logic                               clk,
	input  logic                               rst,
	input  denoise_pkg::block_stats_t          stats,
	input  logic                               stats_done,
	input  logic [denoise_pkg::cfg_data_w-1:0] noise_var,
	output denoise_pkg::gains_t                gains,
	output logic                               gain_done
);

	localparam int var_w = 2 * denoise_pkg::pix_w;
	localparam int gain_w = denoise_pkg::gain_frac + 1;
	localparam int num_w = var_w + denoise_pkg::gain_frac;
	localparam int step_w = $clog2(gain_w);
	localparam logic [step_w-1:0] step_last = step_w'(gain_w - 1);

	logic busy_q;
	logic [1:0] ch_q;
	logic [step_w-1:0] step_q;
	logic [var_w-1:0] var_g_q;
	logic [var_w-1:0] var_b_q;
	logic [denoise_pkg::cfg_data_w-1:0] noise_q;
	logic [var_w-1:0] div_q;
	logic [var_w-1:0] rem_q;
	logic [gain_w-1:0] num_q;
	logic skip_q;

	logic load_start;
	logic load_next;
	logic last_step;
	logic [var_w-1:0] ld_var;
	logic [denoise_pkg::cfg_data_w-1:0] ld_noise;
	logic [var_w-1:0] ld_diff;
	logic [num_w-1:0] ld_num;
	logic [var_w:0] trial;
	logic [var_w:0] rem_n;
	logic fits;
	logic [gain_w-1:0] quo;

	assign load_start = !busy_q && stats_done;
	assign last_step = busy_q && (step_q == step_last);
	assign load_next = last_step && (ch_q != 2'd2);

	// Operands for the channel about to start
	always_comb begin
		if (!busy_q) begin
			ld_var = stats.r.variance;
			ld_noise = noise_var;
		end else begin
			ld_var = (ch_q == 2'd0) ? var_g_q : var_b_q;
			ld_noise = noise_q;
		end
		ld_diff = ld_var - ld_noise;
		ld_num = {ld_diff, {denoise_pkg::gain_frac{1'b0}}};
	end

	// One quotient bit per cycle, numerator bits shift out as quotient bits shift in
	assign trial = {rem_q, num_q[gain_w-1]};
	assign fits = (trial >= {1'b0, div_q});
	assign rem_n = fits ? trial - {1'b0, div_q} : trial;
	assign quo = {num_q[gain_w-2:0], fits};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			ch_q <= '0;
			step_q <= '0;
			gain_done <= 1'b0;
		end else begin
			gain_done <= 1'b0;
			if (load_start) begin
				busy_q <= 1'b1;
				ch_q <= '0;
				step_q <= '0;
			end else if (last_step) begin
				step_q <= '0;
				if (ch_q == 2'd2) begin
					busy_q <= 1'b0;
					gain_done <= 1'b1;
					ch_q <= '0;
				end else begin
					ch_q <= ch_q + 1'b1;
				end
			end else if (busy_q) begin
				step_q <= step_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_start) begin
			var_g_q <= stats.g.variance;
			var_b_q <= stats.b.variance;
			noise_q <= noise_var;
		end
		if (load_start || load_next) begin
			div_q <= ld_var;
			// Covers zero variance too, noise is never negative
			skip_q <= (ld_var <= ld_noise);
			rem_q <= var_w'(ld_num[num_w-1:gain_w]);
			num_q <= ld_num[gain_w-1:0];
		end else if (busy_q) begin
			rem_q <= rem_n[var_w-1:0];
			num_q <= quo;
		end
		if (last_step) begin
			case (ch_q)
				2'd0: gains.r <= skip_q ? '0 : quo;
				2'd1: gains.g <= skip_q ? '0 : quo;
				default: gains.b <= skip_q ? '0 : quo;
			endcase
		end
	end

endmodule

//--- noise_estimator.sv
`timescale 1ns/1ps
// Frame noise estimate from the smallest gray block variance of the previous frame
module noise_estimator #(
	parameter int block_pixels_p = denoise_pkg::block_pixels
) (
	input  logic                               clk,
	input  logic                               rst,
	input  denoise_pkg::frame_cfg_t            cfg,
	input  logic                               noise_init_load,
	input  denoise_pkg::block_stats_t          stats,
	input  logic                               stats_done,
	output logic [denoise_pkg::cfg_data_w-1:0] noise_var
);

	logic [31:0] frame_blocks;
	logic [31:0] blk_cnt_q;
	logic [denoise_pkg::cfg_data_w-1:0] min_q;
	logic [denoise_pkg::cfg_data_w-1:0] min_next;

	assign frame_blocks = (32'(cfg.width) * 32'(cfg.height)) >> $clog2(block_pixels_p);
	assign min_next = (stats.gray.variance < min_q) ? stats.gray.variance : min_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			blk_cnt_q <= '0;
			min_q <= '1;
			noise_var <= '0;
		end else if (noise_init_load) begin
			// New starting estimate, restart the frame search
			noise_var <= cfg.noise_init;
			blk_cnt_q <= '0;
			min_q <= '1;
		end else if (stats_done) begin
			if (blk_cnt_q + 1 >= frame_blocks) begin
				// Last block of the frame
				noise_var <= min_next;
				blk_cnt_q <= '0;
				min_q <= '1;
			end else begin
				blk_cnt_q <= blk_cnt_q + 1;
				min_q <= min_next;
			end
		end
	end

endmodule

//--- block_stats.sv
`timescale 1ns/1ps
// Per-block channel and gray accumulation producing block means and variances
module block_stats #(
	parameter int block_pixels_p = denoise_pkg::block_pixels
) (
	input  logic                      clk,
	input  logic                      rst,
	input  denoise_pkg::pixel_t       pix_in,
	input  logic                      pix_in_valid,
	output denoise_pkg::block_stats_t stats,
	output logic                      stats_done
);

	localparam int cnt_w = $clog2(block_pixels_p);
	localparam int sum_w = denoise_pkg::pix_w + cnt_w;
	localparam int sq_w = 2 * denoise_pkg::pix_w + cnt_w;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(block_pixels_p - 1);

	// Index 0..2 are r, g, b and index 3 is gray
	logic [denoise_pkg::pix_w-1:0] samp [4];
	logic [denoise_pkg::pix_w+1:0] rgb_sum;
	logic [sum_w-1:0] sum_q [4];
	logic [sum_w-1:0] sum_n [4];
	logic [sq_w-1:0] sq_q [4];
	logic [sq_w-1:0] sq_n [4];
	logic [cnt_w-1:0] cnt_q;
	logic last_pix;

	function automatic denoise_pkg::chan_stats_t chan_calc(
		input logic [sum_w-1:0] s,
		input logic [sq_w-1:0] q
	);
		denoise_pkg::chan_stats_t c;
		logic [denoise_pkg::pix_w-1:0] m;
		logic [2*denoise_pkg::pix_w-1:0] ex2;
		m = denoise_pkg::pix_w'(s >> cnt_w);
		ex2 = (2 * denoise_pkg::pix_w)'(q >> cnt_w);
		c.mean = m;
		c.variance = ex2 - m * m;
		return c;
	endfunction

	assign rgb_sum = (denoise_pkg::pix_w + 2)'(pix_in.r) + pix_in.g + pix_in.b;
	assign last_pix = (cnt_q == cnt_last);

	always_comb begin
		samp[0] = pix_in.r;
		samp[1] = pix_in.g;
		samp[2] = pix_in.b;
		samp[3] = denoise_pkg::pix_w'(rgb_sum / 3);
		for (int i = 0; i < 4; i++) begin
			sum_n[i] = sum_q[i] + samp[i];
			sq_n[i] = sq_q[i] + samp[i] * samp[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
			stats_done <= 1'b0;
			for (int i = 0; i < 4; i++) begin
				sum_q[i] <= '0;
				sq_q[i] <= '0;
			end
		end else begin
			stats_done <= pix_in_valid && last_pix;
			if (pix_in_valid) begin
				cnt_q <= cnt_q + 1'b1;
				// Start the next block from zero
				for (int i = 0; i < 4; i++) begin
					sum_q[i] <= last_pix ? '0 : sum_n[i];
					sq_q[i] <= last_pix ? '0 : sq_n[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pix_in_valid && last_pix) begin
			stats.r <= chan_calc(sum_n[0], sq_n[0]);
			stats.g <= chan_calc(sum_n[1], sq_n[1]);
			stats.b <= chan_calc(sum_n[2], sq_n[2]);
			stats.gray <= chan_calc(sum_n[3], sq_n[3]);
		end
	end

endmodule

//--- block_buffer.sv
`timescale 1ns/1ps
// Block pixel store with fill and drain control and the per-pixel Wiener output stage
module block_buffer #(
	parameter int block_pixels_p = denoise_pkg::block_pixels
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      s_valid,
	output logic                      s_ready,
	input  denoise_pkg::pixel_t       s_data,
	input  logic                      s_user,
	output denoise_pkg::pixel_t       pix_in,
	output logic                      pix_in_valid,
	input  denoise_pkg::block_stats_t stats,
	input  denoise_pkg::gains_t       gains,
	input  logic                      gain_done,
	output logic                      m_valid,
	input  logic                      m_ready,
	output denoise_pkg::pixel_t       m_data,
	output logic                      m_last,
	output logic                      m_user
);

	localparam int idx_w = $clog2(block_pixels_p);
	localparam logic [idx_w-1:0] idx_last = idx_w'(block_pixels_p - 1);
	localparam int res_w = 2 * denoise_pkg::pix_w + 4;

	denoise_pkg::buf_state_t state_q;
	logic [idx_w-1:0] idx_q;
	denoise_pkg::pixel_t mem [block_pixels_p];
	denoise_pkg::pixel_t rd_pix;
	denoise_pkg::pixel_t mean_q;
	denoise_pkg::pixel_t mean_sel;
	denoise_pkg::pixel_t filt_pix;
	denoise_pkg::gains_t gains_q;
	denoise_pkg::gains_t gain_sel;
	logic frame_start_q;
	logic in_fire;
	logic out_fire;
	logic load_first;
	logic load_next;

	// mean + (gain * (x - mean)) >>> gain_frac, clamped to the pixel range
	function automatic logic [denoise_pkg::pix_w-1:0] filt(
		input logic [denoise_pkg::pix_w-1:0] x,
		input logic [denoise_pkg::pix_w-1:0] mean,
		input logic [denoise_pkg::gain_frac:0] gain
	);
		logic signed [denoise_pkg::pix_w+1:0] diff;
		logic signed [res_w-1:0] prod;
		logic signed [res_w-1:0] res;
		diff = $signed({2'b00, x}) - $signed({2'b00, mean});
		prod = $signed({1'b0, gain}) * diff;
		res = (prod >>> denoise_pkg::gain_frac) + $signed(res_w'(mean));
		if (res < 0)
			return '0;
		else if (res > (2 ** denoise_pkg::pix_w) - 1)
			return '1;
		else
			return res[denoise_pkg::pix_w-1:0];
	endfunction

	assign s_ready = (state_q == denoise_pkg::fill);
	assign in_fire = s_valid && s_ready;
	assign out_fire = m_valid && m_ready;
	assign pix_in = s_data;
	assign pix_in_valid = in_fire;

	assign load_first = (state_q == denoise_pkg::wait_gain) && gain_done;
	assign load_next = (state_q == denoise_pkg::drain) && out_fire && !m_last;
	assign rd_pix = mem[idx_q];

	// First pixel comes straight from the gain unit, the rest from the held copies
	always_comb begin
		if (state_q == denoise_pkg::wait_gain) begin
			mean_sel.r = stats.r.mean;
			mean_sel.g = stats.g.mean;
			mean_sel.b = stats.b.mean;
			gain_sel = gains;
		end else begin
			mean_sel = mean_q;
			gain_sel = gains_q;
		end
		filt_pix.r = filt(rd_pix.r, mean_sel.r, gain_sel.r);
		filt_pix.g = filt(rd_pix.g, mean_sel.g, gain_sel.g);
		filt_pix.b = filt(rd_pix.b, mean_sel.b, gain_sel.b);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= denoise_pkg::fill;
			idx_q <= '0;
			m_valid <= 1'b0;
		end else begin
			case (state_q)
				denoise_pkg::fill: begin
					if (in_fire) begin
						idx_q <= idx_q + 1'b1;
						if (idx_q == idx_last)
							state_q <= denoise_pkg::wait_gain;
					end
				end
				denoise_pkg::wait_gain: begin
					if (gain_done) begin
						state_q <= denoise_pkg::drain;
						idx_q <= idx_q + 1'b1;
						m_valid <= 1'b1;
					end
				end
				denoise_pkg::drain: begin
					if (out_fire) begin
						// Index has already wrapped to zero once the last pixel loads
						if (m_last) begin
							m_valid <= 1'b0;
							state_q <= denoise_pkg::fill;
						end else begin
							idx_q <= idx_q + 1'b1;
						end
					end
				end
				default: state_q <= denoise_pkg::fill;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			mem[idx_q] <= s_data;
			if (idx_q == '0)
				frame_start_q <= s_user;
		end
		if (load_first) begin
			mean_q <= mean_sel;
			gains_q <= gains;
		end
		if (load_first || load_next) begin
			m_data <= filt_pix;
			m_last <= (idx_q == idx_last);
			m_user <= load_first && frame_start_q;
		end
	end

endmodule

//--- frame_config.sv
`timescale 1ns/1ps
// Frame size and noise_init registers with a registered readback port
module frame_config (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               cfg_we,
	input  logic [denoise_pkg::cfg_addr_w-1:0] cfg_addr,
	input  logic [denoise_pkg::cfg_data_w-1:0] cfg_wdata,
	input  logic [denoise_pkg::cfg_addr_w-1:0] cfg_raddr,
	output logic [denoise_pkg::cfg_data_w-1:0] cfg_rdata,
	input  logic [denoise_pkg::cfg_data_w-1:0] noise_var,
	output denoise_pkg::frame_cfg_t            cfg,
	output logic                               noise_init_load
);

	always_ff @(posedge clk) begin
		if (rst) begin
			// Default frame of 16x8 pixels, two blocks
			cfg.width <= 16'd16;
			cfg.height <= 16'd8;
			cfg.noise_init <= 16'h0040;
			// Estimator picks up noise_init on the first cycle out of reset
			noise_init_load <= 1'b1;
			cfg_rdata <= '0;
		end else begin
			noise_init_load <= cfg_we && (cfg_addr == denoise_pkg::reg_noise_init);

			if (cfg_we) begin
				case (cfg_addr)
					denoise_pkg::reg_width: cfg.width <= cfg_wdata;
					denoise_pkg::reg_height: cfg.height <= cfg_wdata;
					denoise_pkg::reg_noise_init: cfg.noise_init <= cfg_wdata;
					// Estimate register is read only
					default: ;
				endcase
			end

			case (cfg_raddr)
				denoise_pkg::reg_width: cfg_rdata <= cfg.width;
				denoise_pkg::reg_height: cfg_rdata <= cfg.height;
				denoise_pkg::reg_noise_init: cfg_rdata <= cfg.noise_init;
				denoise_pkg::reg_noise_est: cfg_rdata <= noise_var;
				default: cfg_rdata <= '0;
			endcase
		end
	end

endmodule

//--- denoise_pkg.sv
// Shared widths, register map, stream and statistics types of the block denoiser
package denoise_pkg;

	// Pixel and block geometry
	localparam int pix_w = 8;
	localparam int block_dim = 8;
	localparam int block_pixels = block_dim * block_dim;

	// Gains are fixed point with this many fraction bits, 1.0 is 256
	localparam int gain_frac = 8;

	// Register port
	localparam int cfg_addr_w = 2;
	localparam int cfg_data_w = 16;

	localparam logic [cfg_addr_w-1:0] reg_width = cfg_addr_w'(0);
	localparam logic [cfg_addr_w-1:0] reg_height = cfg_addr_w'(1);
	localparam logic [cfg_addr_w-1:0] reg_noise_init = cfg_addr_w'(2);
	localparam logic [cfg_addr_w-1:0] reg_noise_est = cfg_addr_w'(3);

	// RGB pixel, r in the top byte of the low 24 bits
	typedef struct packed {
		logic [pix_w-1:0] r;
		logic [pix_w-1:0] g;
		logic [pix_w-1:0] b;
	} pixel_t;

	// Mean and variance of one channel over a block
	typedef struct packed {
		logic [pix_w-1:0] mean;
		logic [2*pix_w-1:0] variance;
	} chan_stats_t;

	typedef struct packed {
		chan_stats_t r;
		chan_stats_t g;
		chan_stats_t b;
		chan_stats_t gray;
	} block_stats_t;

	typedef struct packed {
		logic [gain_frac:0] r;
		logic [gain_frac:0] g;
		logic [gain_frac:0] b;
	} gains_t;

	typedef struct packed {
		logic [cfg_data_w-1:0] width;
		logic [cfg_data_w-1:0] height;
		logic [cfg_data_w-1:0] noise_init;
	} frame_cfg_t;

	typedef enum logic [1:0] {
		fill,
		wait_gain,
		drain
	} buf_state_t;

endpackage
